//--- include/dma_params.svh
/*
 * Widths, queue depth, TCDM window and register map of the 2D DMA
 */

`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

`define DMA_ADDR_W      32
`define DMA_DATA_W      32
`define DMA_ID_W        8
`define DMA_QUEUE_DEPTH 4

// TCDM window, everything else is external
`define DMA_TCDM_BASE 32'h1000_0000
`define DMA_TCDM_SIZE 32'h1000

// Register word indices
`define DMA_REG_IDX_W      4
`define DMA_REG_SRC        4'd0
`define DMA_REG_DST        4'd1
`define DMA_REG_LEN        4'd2
`define DMA_REG_SRC_STRIDE 4'd3
`define DMA_REG_DST_STRIDE 4'd4
`define DMA_REG_REPS       4'd5
`define DMA_REG_NEXT_ID    4'd6
`define DMA_REG_DONE_ID    4'd7
`define DMA_REG_STATUS     4'd8

`endif

//--- hw/dma_pkg.sv
/*
 * Request, burst and memory port structs and FSM state enums
 */

`default_nettype none

`include "dma_params.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;

  // Register port access
  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`DMA_REG_IDX_W-1:0] idx;
    data_t                     wdata;
  } reg_req_t;

  // 2D transfer, len in words and strides in bytes
  typedef struct packed {
    addr_t src;
    addr_t dst;
    addr_t len;
    addr_t src_stride;
    addr_t dst_stride;
    addr_t reps;
  } nd_req_t;

  // One row of a 2D transfer
  typedef struct packed {
    addr_t src;
    addr_t dst;
    addr_t len;
    logic  last;
  } burst_req_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef enum logic [1:0] {
    BE_IDLE,
    BE_READ,
    BE_WRITE
  } be_state_e;

  typedef enum logic {
    MID_IDLE,
    MID_ROWS
  } mid_state_e;

endpackage

`default_nettype wire

//--- hw/dma_req_fifo.sv
/*
 * Circular FIFO of queued 2D transfer requests
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_req_fifo #(
  parameter int unsigned DEPTH = `DMA_QUEUE_DEPTH
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  dma_pkg::nd_req_t data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output dma_pkg::nd_req_t data_o,
  output logic             valid_o,
  input  logic             ready_i,
  output logic             full_o,
  output logic             empty_o
);
  import dma_pkg::*;

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  nd_req_t         mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;

  assign full_o  = (count_q == CntW'(DEPTH));
  assign empty_o = (count_q == '0);
  assign ready_o = ~full_o;
  assign valid_o = ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dma_reg_frontend.sv
/*
 * Configuration registers, launch logic and transfer ID counters
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_reg_frontend (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  dma_pkg::reg_req_t      cfg_req_i,
  input  logic                   req_ready_i,
  input  logic                   complete_i,
  input  logic                   queue_full_i,
  input  logic                   busy_i,
  output logic [`DMA_DATA_W-1:0] cfg_rdata_o,
  output logic                   cfg_rvalid_o,
  output dma_pkg::nd_req_t       nd_req_o,
  output logic                   req_valid_o
);
  import dma_pkg::*;

  nd_req_t               cfg_q;
  logic [`DMA_ID_W-1:0]  last_id_q;
  logic [`DMA_ID_W-1:0]  done_id_q;
  logic [`DMA_ID_W-1:0]  new_id;
  data_t                 rdata_d;
  logic                  launch_rd;
  logic                  launch_ok;

  // Reading NEXT_ID is the launch command
  assign launch_rd   = cfg_req_i.req & ~cfg_req_i.we & (cfg_req_i.idx == `DMA_REG_NEXT_ID);
  assign req_valid_o = launch_rd & (cfg_q.len != '0) & (cfg_q.reps != '0) & ~queue_full_i;
  assign launch_ok   = req_valid_o & req_ready_i;
  assign new_id      = last_id_q + 1'b1;
  assign nd_req_o    = cfg_q;

  // --------------------------------------------------
  // Read data
  // --------------------------------------------------
  always_comb begin
    rdata_d = '0;
    if (!cfg_req_i.we) begin
      case (cfg_req_i.idx)
        `DMA_REG_SRC:        rdata_d = cfg_q.src;
        `DMA_REG_DST:        rdata_d = cfg_q.dst;
        `DMA_REG_LEN:        rdata_d = cfg_q.len;
        `DMA_REG_SRC_STRIDE: rdata_d = cfg_q.src_stride;
        `DMA_REG_DST_STRIDE: rdata_d = cfg_q.dst_stride;
        `DMA_REG_REPS:       rdata_d = cfg_q.reps;
        `DMA_REG_NEXT_ID: begin
          // Rejected launch answers ID 0
          if (launch_ok) begin
            rdata_d = {{(`DMA_DATA_W-`DMA_ID_W){1'b0}}, new_id};
          end
        end
        `DMA_REG_DONE_ID:    rdata_d = {{(`DMA_DATA_W-`DMA_ID_W){1'b0}}, done_id_q};
        `DMA_REG_STATUS:     rdata_d = {{(`DMA_DATA_W-2){1'b0}}, queue_full_i, busy_i};
        default:             rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_req_i.req) begin
      cfg_rdata_o <= rdata_d;
    end
  end

  // --------------------------------------------------
  // Registers and counters
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q        <= '0;
      last_id_q    <= '0;
      done_id_q    <= '0;
      cfg_rvalid_o <= 1'b0;
    end else begin
      cfg_rvalid_o <= cfg_req_i.req;
      if (cfg_req_i.req && cfg_req_i.we) begin
        case (cfg_req_i.idx)
          `DMA_REG_SRC:        cfg_q.src        <= cfg_req_i.wdata;
          `DMA_REG_DST:        cfg_q.dst        <= cfg_req_i.wdata;
          `DMA_REG_LEN:        cfg_q.len        <= cfg_req_i.wdata;
          `DMA_REG_SRC_STRIDE: cfg_q.src_stride <= cfg_req_i.wdata;
          `DMA_REG_DST_STRIDE: cfg_q.dst_stride <= cfg_req_i.wdata;
          `DMA_REG_REPS:       cfg_q.reps       <= cfg_req_i.wdata;
          default: ;
        endcase
      end
      if (launch_ok) begin
        last_id_q <= new_id;
      end
      // In-order completion
      if (complete_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/dma_2d_midend.sv
/*
 * 2D midend, splits a transfer into rows and signals completion
 */

`timescale 1ns/1ps
`default_nettype none

module dma_2d_midend (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  dma_pkg::nd_req_t    nd_req_i,
  input  logic                nd_valid_i,
  output logic                nd_ready_o,
  output dma_pkg::burst_req_t burst_o,
  output logic                burst_valid_o,
  input  logic                burst_ready_i,
  input  logic                burst_done_i,
  output logic                complete_o,
  output logic                busy_o
);
  import dma_pkg::*;

  mid_state_e state_q;
  addr_t      src_q;
  addr_t      dst_q;
  addr_t      len_q;
  addr_t      src_stride_q;
  addr_t      dst_stride_q;
  addr_t      rows_left_q;
  logic       last_sent_q;
  logic       complete_q;
  logic       nd_take;
  logic       burst_take;

  assign nd_ready_o    = (state_q == MID_IDLE);
  assign nd_take       = nd_valid_i & nd_ready_o;
  assign burst_valid_o = (state_q == MID_ROWS) & (rows_left_q != '0);
  assign burst_take    = burst_valid_o & burst_ready_i;

  assign burst_o.src  = src_q;
  assign burst_o.dst  = dst_q;
  assign burst_o.len  = len_q;
  assign burst_o.last = (rows_left_q == addr_t'(1));

  assign complete_o = complete_q;
  assign busy_o     = (state_q != MID_IDLE);

  // Row addresses, stepped by the strides per accepted row
  always_ff @(posedge clk_i) begin
    if (nd_take) begin
      src_q        <= nd_req_i.src;
      dst_q        <= nd_req_i.dst;
      len_q        <= nd_req_i.len;
      src_stride_q <= nd_req_i.src_stride;
      dst_stride_q <= nd_req_i.dst_stride;
    end else if (burst_take) begin
      src_q <= src_q + src_stride_q;
      dst_q <= dst_q + dst_stride_q;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= MID_IDLE;
      rows_left_q <= '0;
      last_sent_q <= 1'b0;
      complete_q  <= 1'b0;
    end else begin
      complete_q <= 1'b0;
      case (state_q)
        MID_IDLE: begin
          if (nd_take) begin
            state_q     <= MID_ROWS;
            rows_left_q <= nd_req_i.reps;
            last_sent_q <= 1'b0;
          end
        end
        MID_ROWS: begin
          if (burst_take) begin
            rows_left_q <= rows_left_q - 1'b1;
            if (burst_o.last) begin
              last_sent_q <= 1'b1;
            end
          end
          // Only one row is in flight, so this done belongs to the last row
          if (burst_done_i && last_sent_q) begin
            complete_q  <= 1'b1;
            last_sent_q <= 1'b0;
            state_q     <= MID_IDLE;
          end
        end
        default: state_q <= MID_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dma_backend.sv
/*
 * Backend copy engine, one read then one write per word
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_backend (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  dma_pkg::burst_req_t    burst_i,
  input  logic                   burst_valid_i,
  output logic                   burst_ready_o,
  output dma_pkg::mem_req_t      mem_o,
  input  logic [`DMA_DATA_W-1:0] mem_rdata_i,
  output logic                   done_o,
  output logic                   busy_o
);
  import dma_pkg::*;

  be_state_e state_q;
  addr_t     src_q;
  addr_t     dst_q;
  addr_t     left_q;

  assign burst_ready_o = (state_q == BE_IDLE);
  assign busy_o        = (state_q != BE_IDLE);
  assign done_o        = (state_q == BE_WRITE) && (left_q == addr_t'(1));

  // --------------------------------------------------
  // Memory access
  // --------------------------------------------------
  always_comb begin
    mem_o = '0;
    case (state_q)
      BE_READ: begin
        mem_o.req  = 1'b1;
        mem_o.addr = src_q;
      end
      BE_WRITE: begin
        // Read data arrives one cycle after the read
        mem_o.req   = 1'b1;
        mem_o.we    = 1'b1;
        mem_o.addr  = dst_q;
        mem_o.wdata = mem_rdata_i;
      end
      default: mem_o = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (state_q == BE_IDLE && burst_valid_i) begin
      src_q <= burst_i.src;
      dst_q <= burst_i.dst;
    end else if (state_q == BE_WRITE) begin
      src_q <= src_q + addr_t'(4);
      dst_q <= dst_q + addr_t'(4);
    end
  end

  // --------------------------------------------------
  // FSM and word counter
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= BE_IDLE;
      left_q  <= '0;
    end else begin
      case (state_q)
        BE_IDLE: begin
          if (burst_valid_i) begin
            left_q  <= burst_i.len;
            state_q <= BE_READ;
          end
        end
        BE_READ: state_q <= BE_WRITE;
        BE_WRITE: begin
          left_q  <= left_q - 1'b1;
          state_q <= (left_q == addr_t'(1)) ? BE_IDLE : BE_READ;
        end
        default: state_q <= BE_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dma_addr_router.sv
/*
 * Address router between the TCDM and external word ports
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_addr_router (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  dma_pkg::mem_req_t      mem_i,
  output logic [`DMA_DATA_W-1:0] mem_rdata_o,
  output dma_pkg::mem_req_t      tcdm_req_o,
  input  logic [`DMA_DATA_W-1:0] tcdm_rdata_i,
  output dma_pkg::mem_req_t      ext_req_o,
  input  logic [`DMA_DATA_W-1:0] ext_rdata_i
);
  import dma_pkg::*;

  addr_t offset;
  logic  in_tcdm;
  logic  sel_tcdm_q;

  // Addresses below the base wrap to a large offset
  assign offset  = mem_i.addr - `DMA_TCDM_BASE;
  assign in_tcdm = (offset < `DMA_TCDM_SIZE);

  always_comb begin
    tcdm_req_o     = mem_i;
    tcdm_req_o.req = mem_i.req & in_tcdm;
    ext_req_o      = mem_i;
    ext_req_o.req  = mem_i.req & ~in_tcdm;
  end

  // Port of the last read, for the data one cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_tcdm_q <= 1'b0;
    end else if (mem_i.req && !mem_i.we) begin
      sel_tcdm_q <= in_tcdm;
    end
  end

  assign mem_rdata_o = sel_tcdm_q ? tcdm_rdata_i : ext_rdata_i;

endmodule

`default_nettype wire

//--- hw/dma_top.sv
/*
 * DMA top level, frontend, request FIFO, midend, backend and router
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module dma_top (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  dma_pkg::reg_req_t      cfg_req_i,
  output logic [`DMA_DATA_W-1:0] cfg_rdata_o,
  output logic                   cfg_rvalid_o,
  output dma_pkg::mem_req_t      tcdm_req_o,
  input  logic [`DMA_DATA_W-1:0] tcdm_rdata_i,
  output dma_pkg::mem_req_t      ext_req_o,
  input  logic [`DMA_DATA_W-1:0] ext_rdata_i,
  output logic                   term_event_o,
  output logic                   busy_o
);
  import dma_pkg::*;

  nd_req_t    fe_req;
  nd_req_t    fifo_req;
  burst_req_t burst_req;
  mem_req_t   be_mem;
  data_t      be_rdata;
  logic       fe_valid;
  logic       fe_ready;
  logic       fifo_valid;
  logic       fifo_ready;
  logic       fifo_full;
  logic       fifo_empty;
  logic       be_valid;
  logic       be_ready;
  logic       be_done;
  logic       complete;
  logic       mid_busy;
  logic       be_busy;

  // Completion is broadcast as the event
  assign term_event_o = complete;
  assign busy_o       = ~fifo_empty | mid_busy | be_busy;

  dma_reg_frontend u_frontend (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .cfg_req_i    ( cfg_req_i    ),
    .req_ready_i  ( fe_ready     ),
    .complete_i   ( complete     ),
    .queue_full_i ( fifo_full    ),
    .busy_i       ( busy_o       ),
    .cfg_rdata_o  ( cfg_rdata_o  ),
    .cfg_rvalid_o ( cfg_rvalid_o ),
    .nd_req_o     ( fe_req       ),
    .req_valid_o  ( fe_valid     )
  );

  dma_req_fifo #(
    .DEPTH ( `DMA_QUEUE_DEPTH )
  ) u_req_fifo (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .data_i   ( fe_req     ),
    .valid_i  ( fe_valid   ),
    .ready_o  ( fe_ready   ),
    .data_o   ( fifo_req   ),
    .valid_o  ( fifo_valid ),
    .ready_i  ( fifo_ready ),
    .full_o   ( fifo_full  ),
    .empty_o  ( fifo_empty )
  );

  dma_2d_midend u_midend (
    .clk_i         ( clk_i      ),
    .arst_n_i      ( arst_n_i   ),
    .nd_req_i      ( fifo_req   ),
    .nd_valid_i    ( fifo_valid ),
    .nd_ready_o    ( fifo_ready ),
    .burst_o       ( burst_req  ),
    .burst_valid_o ( be_valid   ),
    .burst_ready_i ( be_ready   ),
    .burst_done_i  ( be_done    ),
    .complete_o    ( complete   ),
    .busy_o        ( mid_busy   )
  );

  dma_backend u_backend (
    .clk_i         ( clk_i     ),
    .arst_n_i      ( arst_n_i  ),
    .burst_i       ( burst_req ),
    .burst_valid_i ( be_valid  ),
    .burst_ready_o ( be_ready  ),
    .mem_o         ( be_mem    ),
    .mem_rdata_i   ( be_rdata  ),
    .done_o        ( be_done   ),
    .busy_o        ( be_busy   )
  );

  dma_addr_router u_router (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .mem_i        ( be_mem       ),
    .mem_rdata_o  ( be_rdata     ),
    .tcdm_req_o   ( tcdm_req_o   ),
    .tcdm_rdata_i ( tcdm_rdata_i ),
    .ext_req_o    ( ext_req_o    ),
    .ext_rdata_i  ( ext_rdata_i  )
  );

endmodule

`default_nettype wire

//--- tests/tb_dma_top.sv
/*
 * Testbench for the 2D DMA with clock, reset, TCDM and external memory models,
 * register access tasks, reference copy model and directed tests
 */

`timescale 1ns/1ps
`default_nettype none

`include "dma_params.svh"

module tb_dma_top;
  import dma_pkg::*;

  localparam addr_t TcdmBase = `DMA_TCDM_BASE;

  logic                     clk;
  logic                     arst_n;
  reg_req_t                 cfg_req;
  data_t                    cfg_rdata;
  logic                     cfg_rvalid;
  mem_req_t                 tcdm_req;
  mem_req_t                 ext_req;
  data_t                    tcdm_rdata;
  data_t                    ext_rdata;
  logic                     term_event;
  logic                     busy;

  data_t                    tcdm_mem [1024];
  data_t                    ext_mem  [2048];
  data_t                    tcdm_exp [1024];
  data_t                    ext_exp  [2048];
  logic [31:0]              lfsr_q;
  logic [`DMA_ID_W-1:0]     exp_id;
  int                       term_cnt;
  int                       req_cnt;
  int                       data_errs;
  int                       id_errs;
  int                       bit_errs;
  int                       other_errs;

  dma_top u_dma_top (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .cfg_req_i    ( cfg_req    ),
    .cfg_rdata_o  ( cfg_rdata  ),
    .cfg_rvalid_o ( cfg_rvalid ),
    .tcdm_req_o   ( tcdm_req   ),
    .tcdm_rdata_i ( tcdm_rdata ),
    .ext_req_o    ( ext_req    ),
    .ext_rdata_i  ( ext_rdata  ),
    .term_event_o ( term_event ),
    .busy_o       ( busy       )
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Memory models with data valid one cycle after a read
  // --------------------------------------------------
  always @(negedge clk) begin
    if (tcdm_req.req) begin
      if (tcdm_req.we) tcdm_mem[tcdm_req.addr[11:2]] = tcdm_req.wdata;
      else tcdm_rdata = tcdm_mem[tcdm_req.addr[11:2]];
    end
    if (ext_req.req) begin
      if (ext_req.we) ext_mem[ext_req.addr[12:2]] = ext_req.wdata;
      else ext_rdata = ext_mem[ext_req.addr[12:2]];
    end
  end

  // Event and request counters
  always @(negedge clk) begin
    if (term_event) term_cnt++;
    if (tcdm_req.req || ext_req.req) req_cnt++;
  end

  // Galois LFSR stepped once per bit
  function automatic data_t next_rand_word();
    data_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return w;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input logic [`DMA_ID_W-1:0] got,
                          input logic [`DMA_ID_W-1:0] exp);
    if (got !== exp) begin
      id_errs++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Register port
  // --------------------------------------------------
  task automatic access_reg(input logic we, input logic [`DMA_REG_IDX_W-1:0] idx,
                            input data_t wdata, output data_t rdata);
    int n;
    cfg_req       = '0;
    cfg_req.req   = 1'b1;
    cfg_req.we    = we;
    cfg_req.idx   = idx;
    cfg_req.wdata = wdata;
    @(negedge clk);
    cfg_req = '0;
    n = 0;
    while (!cfg_rvalid && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!cfg_rvalid) begin
      other_errs++;
      $display("Register access to index %0d got no response by %0t", idx, $time);
    end else if (n != 0) begin
      other_errs++;
      $display("Register access to index %0d answered %0d cycles late at %0t",
               idx, n, $time);
    end
    rdata = cfg_rdata;
  endtask

  task automatic write_reg(input logic [`DMA_REG_IDX_W-1:0] idx, input data_t val);
    data_t unused;
    access_reg(1'b1, idx, val, unused);
  endtask

  task automatic read_reg(input logic [`DMA_REG_IDX_W-1:0] idx, output data_t val);
    access_reg(1'b0, idx, '0, val);
  endtask

  task automatic launch(output logic [`DMA_ID_W-1:0] id);
    data_t rd;
    read_reg(`DMA_REG_NEXT_ID, rd);
    id = rd[`DMA_ID_W-1:0];
  endtask

  task automatic configure(input addr_t src, input addr_t dst, input addr_t len,
                           input addr_t ss, input addr_t ds, input addr_t reps);
    write_reg(`DMA_REG_SRC, src);
    write_reg(`DMA_REG_DST, dst);
    write_reg(`DMA_REG_LEN, len);
    write_reg(`DMA_REG_SRC_STRIDE, ss);
    write_reg(`DMA_REG_DST_STRIDE, ds);
    write_reg(`DMA_REG_REPS, reps);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < 2000) begin
      @(negedge clk);
      n++;
    end
    if (busy) begin
      other_errs++;
      $display("DMA still busy after 2000 cycles at %0t", $time);
    end
    // Let the counters see the final cycle
    @(negedge clk);
  endtask

  // --------------------------------------------------
  // Reference model of the expected memory contents
  // --------------------------------------------------
  function automatic logic in_tcdm(input addr_t a);
    return (a >= TcdmBase) && (a < TcdmBase + `DMA_TCDM_SIZE);
  endfunction

  function automatic data_t exp_read(input addr_t a);
    if (in_tcdm(a)) return tcdm_exp[a[11:2]];
    return ext_exp[a[12:2]];
  endfunction

  function automatic void exp_write(input addr_t a, input data_t d);
    if (in_tcdm(a)) tcdm_exp[a[11:2]] = d;
    else ext_exp[a[12:2]] = d;
  endfunction

  // Word w of row r goes from src + r*ss + 4w to dst + r*ds + 4w
  task automatic model_copy(input addr_t src, input addr_t dst, input addr_t len,
                            input addr_t ss, input addr_t ds, input addr_t reps);
    for (addr_t r = 0; r < reps; r++) begin
      for (addr_t w = 0; w < len; w++) begin
        exp_write(dst + r * ds + (w << 2), exp_read(src + r * ss + (w << 2)));
      end
    end
  endtask

  task automatic check_mems();
    for (int i = 0; i < 1024; i++) begin
      check_data($sformatf("tcdm_mem[%0d]", i), tcdm_mem[i[9:0]], tcdm_exp[i[9:0]]);
    end
    for (int i = 0; i < 2048; i++) begin
      check_data($sformatf("ext_mem[%0d]", i), ext_mem[i[10:0]], ext_exp[i[10:0]]);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_and_regs();
    data_t vals [6];
    data_t rd;
    check_bit("busy_o", busy, 1'b0);
    check_bit("term_event_o", term_event, 1'b0);
    check_bit("cfg_rvalid_o", cfg_rvalid, 1'b0);
    check_bit("tcdm_req_o.req", tcdm_req.req, 1'b0);
    check_bit("ext_req_o.req", ext_req.req, 1'b0);
    read_reg(`DMA_REG_DONE_ID, rd);
    check_id("DONE_ID", rd[`DMA_ID_W-1:0], '0);
    for (int i = 0; i < 6; i++) begin
      vals[i] = next_rand_word();
      write_reg(i[`DMA_REG_IDX_W-1:0], vals[i]);
    end
    for (int i = 0; i < 6; i++) begin
      read_reg(i[`DMA_REG_IDX_W-1:0], rd);
      check_data($sformatf("register %0d", i), rd, vals[i]);
    end
  endtask

  task automatic copy_1d();
    logic [`DMA_ID_W-1:0] id;
    data_t                rd;
    int                   t0;
    configure(32'h100, TcdmBase, 8, 32, 32, 1);
    model_copy(32'h100, TcdmBase, 8, 32, 32, 1);
    t0 = term_cnt;
    launch(id);
    exp_id = exp_id + 1'b1;
    check_id("launch id", id, exp_id);
    wait_idle();
    check_data("term_event_o pulses", data_t'(term_cnt - t0), 1);
    check_mems();
    read_reg(`DMA_REG_DONE_ID, rd);
    check_id("DONE_ID", rd[`DMA_ID_W-1:0], exp_id);
  endtask

  // Strides wider than a row leave gaps in the destination
  task automatic copy_2d();
    logic [`DMA_ID_W-1:0] id;
    data_t                rd;
    int                   t0;
    configure(TcdmBase + 32'h100, 32'h800, 4, 32'h40, 32'h30, 3);
    model_copy(TcdmBase + 32'h100, 32'h800, 4, 32'h40, 32'h30, 3);
    t0 = term_cnt;
    launch(id);
    exp_id = exp_id + 1'b1;
    check_id("launch id", id, exp_id);
    wait_idle();
    check_data("term_event_o pulses", data_t'(term_cnt - t0), 1);
    check_mems();
    read_reg(`DMA_REG_DONE_ID, rd);
    check_id("DONE_ID", rd[`DMA_ID_W-1:0], exp_id);
  endtask

  task automatic reject_zero_size();
    logic [`DMA_ID_W-1:0] id;
    int                   r0;
    logic                 busy_seen;
    configure(32'h200, TcdmBase + 32'h200, 0, 32, 32, 1);
    r0 = req_cnt;
    busy_seen = 1'b0;
    launch(id);
    check_id("launch id, len 0", id, '0);
    write_reg(`DMA_REG_LEN, 4);
    write_reg(`DMA_REG_REPS, 0);
    launch(id);
    check_id("launch id, reps 0", id, '0);
    for (int n = 0; n < 20; n++) begin
      @(negedge clk);
      busy_seen = busy_seen | busy;
    end
    check_bit("busy_o", busy_seen, 1'b0);
    check_data("memory requests", data_t'(req_cnt - r0), 0);
  endtask

  task automatic fill_queue();
    logic [`DMA_ID_W-1:0] id;
    data_t                rd;
    addr_t                src;
    addr_t                dst;
    int                   t0;
    t0 = term_cnt;
    configure(32'h1000, TcdmBase + 32'h400, 8, 32, 32, 4);
    for (int k = 0; k <= `DMA_QUEUE_DEPTH; k++) begin
      src = 32'h1000 + addr_t'(k) * 32'h80;
      dst = TcdmBase + 32'h400 + addr_t'(k) * 32'h80;
      write_reg(`DMA_REG_SRC, src);
      write_reg(`DMA_REG_DST, dst);
      model_copy(src, dst, 8, 32, 32, 4);
      launch(id);
      exp_id = exp_id + 1'b1;
      check_id("launch id", id, exp_id);
    end
    read_reg(`DMA_REG_STATUS, rd);
    check_bit("STATUS queue full", rd[1], 1'b1);
    check_bit("STATUS busy", rd[0], 1'b1);
    launch(id);
    check_id("launch id, queue full", id, '0);
    wait_idle();
    check_data("term_event_o pulses", data_t'(term_cnt - t0), `DMA_QUEUE_DEPTH + 1);
    check_mems();
    read_reg(`DMA_REG_DONE_ID, rd);
    check_id("DONE_ID", rd[`DMA_ID_W-1:0], exp_id);
    read_reg(`DMA_REG_STATUS, rd);
    check_data("STATUS", rd, '0);
    check_bit("busy_o", busy, 1'b0);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clk        = 1'b0;
    arst_n     = 1'b0;
    cfg_req    = '0;
    tcdm_rdata = '0;
    ext_rdata  = '0;
    lfsr_q     = 32'hd878;
    exp_id     = '0;
    term_cnt   = 0;
    req_cnt    = 0;
    data_errs  = 0;
    id_errs    = 0;
    bit_errs   = 0;
    other_errs = 0;
    for (int i = 0; i < 1024; i++) begin
      tcdm_mem[i[9:0]] = next_rand_word();
      tcdm_exp[i[9:0]] = tcdm_mem[i[9:0]];
    end
    for (int i = 0; i < 2048; i++) begin
      ext_mem[i[10:0]] = next_rand_word();
      ext_exp[i[10:0]] = ext_mem[i[10:0]];
    end
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    reset_and_regs();
    copy_1d();
    copy_2d();
    reject_zero_size();
    fill_queue();

    $display("Errors: data %0d, id %0d, flag %0d, other %0d",
             data_errs, id_errs, bit_errs, other_errs);
    if (data_errs + id_errs + bit_errs + other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/dma_pkg.sv
hw/dma_req_fifo.sv
hw/dma_reg_frontend.sv
hw/dma_2d_midend.sv
hw/dma_backend.sv
hw/dma_addr_router.sv
hw/dma_top.sv
tests/tb_dma_top.sv

//--- run.sh
#!/bin/sh
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_dma_top -f list.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_dma_top > sim.log 2>&1
cat sim.log
! grep -q "TESTS FAILED" sim.log && grep -q "TESTS PASSED" sim.log && exit 0 || exit 1
